/* common/scope_pkg.sv */
//--------------------
// shared widths, opcodes and reply kinds of the command processor
// thresholds are signed, in sample units
// spi byte counts other than 3 or 4 run as 2 bytes
//--------------------
`default_nettype none

package scope_pkg;

	// ------------------
	localparam int SAMPLE_W  = 12;
	localparam int WORD_W    = 32;
	localparam int BYTE_W    = 8;
	localparam int CMD_BYTES = 8;
	localparam int BUF_DEPTH = 64;          // samples
	localparam int BUF_AW    = 6;

	localparam logic [WORD_W-1:0] FW_VERSION = 32'd11;

	localparam logic signed [SAMPLE_W-1:0] THRESH_LO = -12'sd10;
	localparam logic signed [SAMPLE_W-1:0] THRESH_HI = 12'sd10;

	localparam int CS_SETUP_CYC = 6;        // cs low to first byte
	localparam int CS_HOLD_CYC  = 16;       // read-back to cs high
	localparam int NUM_CS       = 8;

	// ------------------
	typedef enum logic [7:0] {
		OP_READ_DATA = 8'd0,
		OP_VERSION   = 8'd2,
		OP_SPI       = 8'd3,
		OP_SPI_MODE  = 8'd4,
		OP_ARM       = 8'd5
	} cmd_op_e;

	typedef enum logic [7:0] {
		TRIG_NONE   = 8'd0,
		TRIG_THRESH = 8'd1
	} trig_mode_e;

	typedef enum logic [1:0] {
		REPLY_VERSION,
		REPLY_ECHO,
		REPLY_SPI,
		REPLY_DATA
	} reply_kind_e;

endpackage

`default_nettype wire

/* command/cmd_receiver.sv */
//--------------------
// collects 8-byte commands, byte 0 is the opcode
// engines are driven over four-phase req/ack
// unknown opcodes are dropped without a reply
//--------------------
`timescale 1ns/10ps
`default_nettype none

module cmd_receiver (
	input  logic                                                  clk,
	input  logic                                                  rstn,
	input  logic                                                  i_cmd_valid,
	input  logic [scope_pkg::BYTE_W-1:0]                          i_cmd_data,
	output logic                                                  o_cmd_ready,
	input  logic                                                  i_spi_ack,
	input  logic                                                  i_arm_ack,
	input  logic                                                  i_reply_ack,
	output logic [scope_pkg::CMD_BYTES-1:0][scope_pkg::BYTE_W-1:0] o_cmd_bytes,
	output logic                                                  o_spi_req,
	output logic                                                  o_arm_req,
	output logic                                                  o_reply_req,
	output scope_pkg::reply_kind_e                                o_reply_kind,
	output logic [scope_pkg::WORD_W-1:0]                          o_reply_len,
	output logic [1:0]                                            o_spi_mode
);
	import scope_pkg::*;

	typedef enum logic [2:0] {S_RX, S_DECODE, S_SPI, S_SPI_DROP, S_WAIT_ACK, S_DROP} state_e;

	state_e                       state;
	logic [$clog2(CMD_BYTES)-1:0] byte_cnt;

	assign o_cmd_ready = (state == S_RX);

	always_ff @(posedge clk) begin
		if (o_cmd_ready && i_cmd_valid)
			o_cmd_bytes[byte_cnt] <= i_cmd_data;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= S_RX;
			byte_cnt    <= '0;
			o_spi_req   <= 1'b0;
			o_arm_req   <= 1'b0;
			o_reply_req <= 1'b0;
			o_spi_mode  <= '0;
		end else begin
			case (state)
				S_RX: if (i_cmd_valid) begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == 3'(CMD_BYTES - 1))
						state <= S_DECODE;
				end
				S_DECODE: begin
					o_reply_len <= 32'd4;
					state       <= S_WAIT_ACK;
					case (cmd_op_e'(o_cmd_bytes[0]))
						OP_READ_DATA: begin
							o_reply_kind <= REPLY_DATA;
							o_reply_len  <= {o_cmd_bytes[7], o_cmd_bytes[6],
								o_cmd_bytes[5], o_cmd_bytes[4]};    // little-endian
							o_reply_req  <= 1'b1;
						end
						OP_VERSION: begin
							o_reply_kind <= REPLY_VERSION;
							o_reply_req  <= 1'b1;
						end
						OP_SPI: begin
							o_spi_req <= 1'b1;
							state     <= S_SPI;
						end
						OP_SPI_MODE: begin
							o_spi_mode   <= o_cmd_bytes[1][1:0];
							o_reply_kind <= REPLY_ECHO;
							o_reply_req  <= 1'b1;
						end
						OP_ARM: o_arm_req <= 1'b1;             // no reply
						default: state <= S_RX;
					endcase
				end
				S_SPI: if (i_spi_ack) begin
					o_spi_req <= 1'b0;
					state     <= S_SPI_DROP;
				end
				S_SPI_DROP: if (!i_spi_ack) begin                // then reply with rx byte
					o_reply_kind <= REPLY_SPI;
					o_reply_req  <= 1'b1;
					state        <= S_WAIT_ACK;
				end
				S_WAIT_ACK: if (i_arm_ack || i_reply_ack) begin
					o_arm_req   <= 1'b0;
					o_reply_req <= 1'b0;
					state       <= S_DROP;
				end
				default: if (!i_arm_ack && !i_reply_ack)
					state <= S_RX;
			endcase
		end
	end

endmodule

`default_nettype wire

/* spi/spi_sequencer.sv */
//--------------------
// one spi transaction on an external byte-level master
// sends bytes 2.. of the command, count from byte 7 (2, 3 or 4)
// returns the first rx byte after the last send
//--------------------
`timescale 1ns/10ps
`default_nettype none

module spi_sequencer (
	input  logic                                                  clk,
	input  logic                                                  rstn,
	input  logic                                                  i_spi_req,
	input  logic [scope_pkg::CMD_BYTES-1:0][scope_pkg::BYTE_W-1:0] i_cmd_bytes,
	output logic                                                  o_spi_ack,
	output logic [scope_pkg::BYTE_W-1:0]                          o_spi_tx,
	output logic                                                  o_spi_tx_dv,
	input  logic                                                  i_spi_tx_ready,
	input  logic [scope_pkg::BYTE_W-1:0]                          i_spi_rx,
	input  logic                                                  i_spi_rx_dv,
	output logic [scope_pkg::NUM_CS-1:0]                          o_spi_cs_n,
	output logic [$clog2(scope_pkg::NUM_CS)-1:0]                  o_spi_miso_sel,
	output logic [scope_pkg::BYTE_W-1:0]                          o_spi_rx_byte
);
	import scope_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_SETUP, S_SEND, S_GAP, S_RECV, S_HOLD, S_ACK} state_e;

	state_e                    state;
	logic [3:0]                wait_cnt;
	logic [1:0]                byte_idx;
	logic [1:0]                last_idx;
	logic [$clog2(NUM_CS)-1:0] cs_sel;

	assign cs_sel = i_cmd_bytes[1][$clog2(NUM_CS)-1:0];

	always_comb begin
		case (i_cmd_bytes[7])
			8'd3:    last_idx = 2'd2;
			8'd4:    last_idx = 2'd3;
			default: last_idx = 2'd1;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= S_IDLE;
			o_spi_ack      <= 1'b0;
			o_spi_tx_dv    <= 1'b0;
			o_spi_cs_n     <= '1;
			o_spi_miso_sel <= '0;
			wait_cnt       <= '0;
			byte_idx       <= '0;
		end else begin
			case (state)
				S_IDLE: if (i_spi_req) begin
					o_spi_cs_n     <= ~(NUM_CS'(1) << cs_sel);
					o_spi_miso_sel <= cs_sel;
					wait_cnt       <= '0;
					byte_idx       <= '0;
					state          <= S_SETUP;
				end
				S_SETUP: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == 4'(CS_SETUP_CYC - 1))
						state <= S_SEND;
				end
				S_SEND: if (i_spi_tx_ready) begin
					o_spi_tx    <= i_cmd_bytes[3'd2 + 3'(byte_idx)];
					o_spi_tx_dv <= 1'b1;
					byte_idx    <= byte_idx + 1'b1;
					state       <= (byte_idx == last_idx) ? S_RECV : S_GAP;
				end
				S_GAP: begin                                 // let the master drop ready
					o_spi_tx_dv <= 1'b0;
					state       <= S_SEND;
				end
				S_RECV: begin
					o_spi_tx_dv <= 1'b0;
					if (i_spi_rx_dv && !o_spi_tx_dv) begin   // skip a late rx of the prior byte
						o_spi_rx_byte <= i_spi_rx;
						wait_cnt      <= '0;
						state         <= S_HOLD;
					end
				end
				S_HOLD: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == 4'(CS_HOLD_CYC - 1)) begin
						o_spi_cs_n <= '1;
						o_spi_ack  <= 1'b1;
						state      <= S_ACK;
					end
				end
				default: if (!i_spi_req) begin
					o_spi_ack <= 1'b0;
					state     <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* capture/trigger_capture.sv */
//--------------------
// arm from byte 1 (trigger mode) and bytes 5:4 (sample count)
// count is clamped to the buffer depth
// an arm during a capture is acked and ignored
//--------------------
`timescale 1ns/10ps
`default_nettype none

module trigger_capture (
	input  logic                                                  clk,
	input  logic                                                  rstn,
	input  logic                                                  i_arm_req,
	input  logic [scope_pkg::CMD_BYTES-1:0][scope_pkg::BYTE_W-1:0] i_cmd_bytes,
	input  logic signed [scope_pkg::SAMPLE_W-1:0]                 i_adc_sample,
	input  logic                                                  i_adc_valid,
	input  logic [scope_pkg::BUF_AW-1:0]                          i_rd_addr,
	output logic                                                  o_arm_ack,
	output logic                                                  o_capture_done,
	output logic [scope_pkg::BUF_AW:0]                            o_buf_count,
	output logic [scope_pkg::SAMPLE_W-1:0]                        o_buf_rdata
);
	import scope_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_WAIT_LO, S_WAIT_HI, S_STORE} state_e;

	state_e              state;
	logic [BUF_AW:0]     target;
	logic [15:0]         req_len;
	logic                arm_new;
	logic                cross_hi;
	logic                wr_en;
	logic [SAMPLE_W-1:0] mem [BUF_DEPTH];

	assign req_len  = {i_cmd_bytes[5], i_cmd_bytes[4]};
	assign arm_new  = i_arm_req && !o_arm_ack;
	assign cross_hi = i_adc_valid && (i_adc_sample > THRESH_HI);
	// the crossing sample itself opens the run
	assign wr_en    = (state == S_STORE && i_adc_valid && o_buf_count != target) ||
		(state == S_WAIT_HI && cross_hi && target != '0);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= S_IDLE;
			o_arm_ack      <= 1'b0;
			o_capture_done <= 1'b0;
			o_buf_count    <= '0;
			target         <= '0;
		end else begin
			if (arm_new)
				o_arm_ack <= 1'b1;
			else if (!i_arm_req)
				o_arm_ack <= 1'b0;

			if (wr_en)
				o_buf_count <= o_buf_count + 1'b1;

			case (state)
				S_IDLE: if (arm_new) begin
					o_capture_done <= 1'b0;
					o_buf_count    <= '0;
					target         <= (req_len > 16'(BUF_DEPTH)) ?
						(BUF_AW+1)'(BUF_DEPTH) : req_len[BUF_AW:0];
					state          <= (i_cmd_bytes[1] == TRIG_THRESH) ? S_WAIT_LO : S_STORE;
				end
				S_WAIT_LO: if (i_adc_valid && i_adc_sample < THRESH_LO)
					state <= S_WAIT_HI;
				S_WAIT_HI: if (cross_hi)
					state <= S_STORE;
				default: if (o_buf_count == target) begin
					o_capture_done <= 1'b1;
					state          <= S_IDLE;
				end
			endcase
		end
	end

	// sample buffer, registered read
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[o_buf_count[BUF_AW-1:0]] <= i_adc_sample;
		o_buf_rdata <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

/* logic/reply_streamer.sv */
//--------------------
// streams reply words with keep/last from the bytes remaining
// data words pack two samples with the low sample in bits 15:0
// samples past the stored count read as zero
//--------------------
`timescale 1ns/10ps
`default_nettype none

module reply_streamer (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            i_reply_req,
	input  scope_pkg::reply_kind_e          i_reply_kind,
	input  logic [scope_pkg::WORD_W-1:0]    i_reply_len,
	input  logic [scope_pkg::BYTE_W-1:0]    i_echo_byte,
	input  logic [scope_pkg::BYTE_W-1:0]    i_spi_rx_byte,
	input  logic                            i_capture_done,
	input  logic [scope_pkg::BUF_AW:0]      i_buf_count,
	input  logic [scope_pkg::SAMPLE_W-1:0]  i_buf_rdata,
	output logic                            o_reply_ack,
	output logic [scope_pkg::BUF_AW-1:0]    o_rd_addr,
	output logic                            o_rep_valid,
	output logic [scope_pkg::WORD_W-1:0]    o_rep_data,
	output logic [3:0]                      o_rep_keep,
	output logic                            o_rep_last,
	input  logic                            i_rep_ready
);
	import scope_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_CONST, S_WAIT_DONE, S_DATA, S_ACK} state_e;

	state_e              state;
	logic [WORD_W-1:0]   remain;
	logic [1:0]          fph;
	logic                pf_valid;
	logic [WORD_W-1:0]   pf_data;
	logic [BUF_AW-1:0]   smp_addr;
	logic [WORD_W/2-1:0] smp_half;
	logic                take;

	assign take     = o_rep_valid && i_rep_ready;
	assign smp_addr = o_rd_addr - 1'b1;                  // address behind rdata
	assign smp_half = ({1'b0, smp_addr} < i_buf_count) ? (WORD_W/2)'(i_buf_rdata) : '0;

	assign o_rep_last = (remain <= 32'd4);

	always_comb begin
		if (remain >= 32'd4)
			o_rep_keep = 4'b1111;
		else begin
			case (remain[1:0])
				2'd3:    o_rep_keep = 4'b0111;
				2'd2:    o_rep_keep = 4'b0011;
				2'd1:    o_rep_keep = 4'b0001;
				default: o_rep_keep = 4'b0000;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= S_IDLE;
			o_reply_ack <= 1'b0;
			o_rep_valid <= 1'b0;
			o_rd_addr   <= '0;
			remain      <= '0;
			fph         <= '0;
			pf_valid    <= 1'b0;
		end else begin
			if (take)
				remain <= o_rep_last ? '0 : remain - 32'd4;

			case (state)
				S_IDLE: if (i_reply_req) begin
					remain    <= i_reply_len;
					o_rd_addr <= '0;
					fph       <= '0;
					pf_valid  <= 1'b0;
					case (i_reply_kind)
						REPLY_VERSION: o_rep_data <= FW_VERSION;
						REPLY_ECHO:    o_rep_data <= WORD_W'(i_echo_byte);
						REPLY_SPI:     o_rep_data <= WORD_W'(i_spi_rx_byte);
						default:       o_rep_data <= '0;
					endcase
					if (i_reply_kind == REPLY_DATA)
						state <= S_WAIT_DONE;
					else begin
						o_rep_valid <= 1'b1;
						state       <= S_CONST;
					end
				end
				S_CONST: if (take) begin
					o_rep_valid <= 1'b0;
					o_reply_ack <= 1'b1;
					state       <= S_ACK;
				end
				S_WAIT_DONE: begin
					if (remain == '0) begin                 // empty read-out
						o_reply_ack <= 1'b1;
						state       <= S_ACK;
					end else if (i_capture_done)
						state <= S_DATA;
				end
				S_DATA: begin
					// ------------------
					// pair fetch runs ahead of a stalled word
					case (fph)
						2'd0: if (!pf_valid) begin
							o_rd_addr <= o_rd_addr + 1'b1;
							fph       <= 2'd1;
						end
						2'd1: begin
							pf_data[WORD_W/2-1:0] <= smp_half;
							o_rd_addr             <= o_rd_addr + 1'b1;
							fph                   <= 2'd2;
						end
						default: begin
							pf_data[WORD_W-1:WORD_W/2] <= smp_half;
							pf_valid                   <= 1'b1;
							fph                        <= 2'd0;
						end
					endcase

					if (take && o_rep_last) begin
						o_rep_valid <= 1'b0;
						o_reply_ack <= 1'b1;
						state       <= S_ACK;
					end else if (pf_valid && (!o_rep_valid || take)) begin
						o_rep_data  <= pf_data;
						o_rep_valid <= 1'b1;
						pf_valid    <= 1'b0;
					end else if (take)
						o_rep_valid <= 1'b0;               // next pair not fetched yet
				end
				default: if (!i_reply_req) begin
					o_reply_ack <= 1'b0;
					state       <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/scope_cmd_top.sv */
//--------------------
// command processor top, single clock domain
// spi master and adc sit outside
//--------------------
`timescale 1ns/10ps
`default_nettype none

module scope_cmd_top (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic                                 i_cmd_valid,
	input  logic [scope_pkg::BYTE_W-1:0]         i_cmd_data,
	output logic                                 o_cmd_ready,
	output logic                                 o_rep_valid,
	output logic [scope_pkg::WORD_W-1:0]         o_rep_data,
	output logic [3:0]                           o_rep_keep,
	output logic                                 o_rep_last,
	input  logic                                 i_rep_ready,
	output logic [scope_pkg::BYTE_W-1:0]         o_spi_tx,
	output logic                                 o_spi_tx_dv,
	input  logic                                 i_spi_tx_ready,
	input  logic [scope_pkg::BYTE_W-1:0]         i_spi_rx,
	input  logic                                 i_spi_rx_dv,
	output logic [scope_pkg::NUM_CS-1:0]         o_spi_cs_n,
	output logic [$clog2(scope_pkg::NUM_CS)-1:0] o_spi_miso_sel,
	output logic [1:0]                           o_spi_mode,
	input  logic signed [scope_pkg::SAMPLE_W-1:0] i_adc_sample,
	input  logic                                 i_adc_valid
);
	import scope_pkg::*;

	logic [CMD_BYTES-1:0][BYTE_W-1:0] cmd_bytes;
	logic                             spi_req;
	logic                             spi_ack;
	logic                             arm_req;
	logic                             arm_ack;
	logic                             reply_req;
	logic                             reply_ack;
	reply_kind_e                      reply_kind;
	logic [WORD_W-1:0]                reply_len;
	logic [BYTE_W-1:0]                spi_rx_byte;
	logic                             capture_done;
	logic [BUF_AW:0]                  buf_count;
	logic [SAMPLE_W-1:0]              buf_rdata;
	logic [BUF_AW-1:0]                rd_addr;

	cmd_receiver u_cmd_receiver (
		.clk          (clk),
		.rstn         (rstn),
		.i_cmd_valid  (i_cmd_valid),
		.i_cmd_data   (i_cmd_data),
		.o_cmd_ready  (o_cmd_ready),
		.i_spi_ack    (spi_ack),
		.i_arm_ack    (arm_ack),
		.i_reply_ack  (reply_ack),
		.o_cmd_bytes  (cmd_bytes),
		.o_spi_req    (spi_req),
		.o_arm_req    (arm_req),
		.o_reply_req  (reply_req),
		.o_reply_kind (reply_kind),
		.o_reply_len  (reply_len),
		.o_spi_mode   (o_spi_mode)
	);

	spi_sequencer u_spi_sequencer (
		.clk            (clk),
		.rstn           (rstn),
		.i_spi_req      (spi_req),
		.i_cmd_bytes    (cmd_bytes),
		.o_spi_ack      (spi_ack),
		.o_spi_tx       (o_spi_tx),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx       (i_spi_rx),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.o_spi_cs_n     (o_spi_cs_n),
		.o_spi_miso_sel (o_spi_miso_sel),
		.o_spi_rx_byte  (spi_rx_byte)
	);

	trigger_capture u_trigger_capture (
		.clk            (clk),
		.rstn           (rstn),
		.i_arm_req      (arm_req),
		.i_cmd_bytes    (cmd_bytes),
		.i_adc_sample   (i_adc_sample),
		.i_adc_valid    (i_adc_valid),
		.i_rd_addr      (rd_addr),
		.o_arm_ack      (arm_ack),
		.o_capture_done (capture_done),
		.o_buf_count    (buf_count),
		.o_buf_rdata    (buf_rdata)
	);

	reply_streamer u_reply_streamer (
		.clk            (clk),
		.rstn           (rstn),
		.i_reply_req    (reply_req),
		.i_reply_kind   (reply_kind),
		.i_reply_len    (reply_len),
		.i_echo_byte    (cmd_bytes[1]),     // mode byte echoed back
		.i_spi_rx_byte  (spi_rx_byte),
		.i_capture_done (capture_done),
		.i_buf_count    (buf_count),
		.i_buf_rdata    (buf_rdata),
		.o_reply_ack    (reply_ack),
		.o_rd_addr      (rd_addr),
		.o_rep_valid    (o_rep_valid),
		.o_rep_data     (o_rep_data),
		.o_rep_keep     (o_rep_keep),
		.o_rep_last     (o_rep_last),
		.i_rep_ready    (i_rep_ready)
	);

endmodule

`default_nettype wire

/* bench/scope_cmd_assert.sv */
//--------------------
// stream and spi port checks, bound to the top level
//--------------------
`timescale 1ns/10ps
`default_nettype none

module scope_cmd_assert (
	input logic        clk,
	input logic        rstn,
	input logic        i_rep_valid,
	input logic        i_rep_ready,
	input logic [31:0] i_rep_data,
	input logic [3:0]  i_rep_keep,
	input logic        i_rep_last,
	input logic        i_spi_tx_dv,
	input logic        i_spi_tx_ready,
	input logic [7:0]  i_spi_cs_n
);

	a_stall_stable: assert property (@(posedge clk) disable iff (!rstn)
		(i_rep_valid && !i_rep_ready) |=> (i_rep_valid && $stable(i_rep_data) &&
		$stable(i_rep_keep) && $stable(i_rep_last)))
		else $error("reply word changed while stalled");

	a_keep_nonzero: assert property (@(posedge clk) disable iff (!rstn)
		i_rep_valid |-> (i_rep_keep != 4'b0000))
		else $error("reply keep is zero while valid");

	a_one_cs: assert property (@(posedge clk) disable iff (!rstn)
		$countones(~i_spi_cs_n) <= 1)
		else $error("more than one chip select low");

	a_tx_ready: assert property (@(posedge clk) disable iff (!rstn)
		i_spi_tx_dv |-> i_spi_tx_ready)
		else $error("spi byte offered while master not ready");

endmodule

bind scope_cmd_top scope_cmd_assert u_assert (
	.clk            (clk),
	.rstn           (rstn),
	.i_rep_valid    (o_rep_valid),
	.i_rep_ready    (i_rep_ready),
	.i_rep_data     (o_rep_data),
	.i_rep_keep     (o_rep_keep),
	.i_rep_last     (o_rep_last),
	.i_spi_tx_dv    (o_spi_tx_dv),
	.i_spi_tx_ready (i_spi_tx_ready),
	.i_spi_cs_n     (o_spi_cs_n)
);

`default_nettype wire

/* bench/tb_scope_cmd.sv */
//--------------------
// testbench for the command processor top
// spi master model answers with the inverse of the last byte sent
// data words hold two 12-bit samples, each zero-extended to 16 bits
// run is bounded by a watchdog sized from the command count
//--------------------
`timescale 1ns/10ps
`default_nettype none

module tb_scope_cmd;
	import scope_pkg::*;

	localparam logic [31:0] SEED         = 32'h0eb02589;
	localparam int          NUM_CMDS     = 12;
	localparam int          CAP_LEN_SUM  = 16;         // 10 + 6 samples
	localparam int          WATCHDOG_CYC = 200 * (NUM_CMDS + CAP_LEN_SUM);

	logic                       clk            = 1'b0;
	logic                       rstn           = 1'b0;
	logic                       i_cmd_valid    = 1'b0;
	logic [BYTE_W-1:0]          i_cmd_data     = '0;
	logic                       i_rep_ready    = 1'b0;
	logic                       i_spi_tx_ready = 1'b1;
	logic [BYTE_W-1:0]          i_spi_rx       = '0;
	logic                       i_spi_rx_dv    = 1'b0;
	logic signed [SAMPLE_W-1:0] i_adc_sample   = '0;
	logic                       i_adc_valid    = 1'b0;

	logic                       o_cmd_ready;
	logic                       o_rep_valid;
	logic [WORD_W-1:0]          o_rep_data;
	logic [3:0]                 o_rep_keep;
	logic                       o_rep_last;
	logic [BYTE_W-1:0]          o_spi_tx;
	logic                       o_spi_tx_dv;
	logic [NUM_CS-1:0]          o_spi_cs_n;
	logic [2:0]                 o_spi_miso_sel;
	logic [1:0]                 o_spi_mode;

	logic [WORD_W-1:0]          exp_data [$];
	logic [3:0]                 exp_keep [$];
	logic                       exp_last [$];
	logic signed [SAMPLE_W-1:0] cap_q [$];       // samples the buffer should hold
	logic [BYTE_W-1:0]          spi_seen [$];

	int                         err_cnt    = 0;
	int                         n_tests    = 0;
	int                         n_fail     = 0;
	int                         test_err0  = 0;
	int                         spi_busy   = 0;
	logic                       hold_ready = 1'b0;
	logic [NUM_CS-1:0]          exp_cs_n   = '1;
	logic [2:0]                 exp_sel    = '0;
	logic [BYTE_W-1:0]          last_tx    = '0;

	scope_cmd_top uut (.*);

	always #2 clk = ~clk;

	// --------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (err_cnt == test_err0)
			$display("test %0d %s: ok", n_tests, name);
		else begin
			$display("test %0d %s: failed with %0d errors", n_tests, name, err_cnt - test_err0);
			n_fail++;
		end
		test_err0 = err_cnt;
	endtask

	// expected words of one reply, pushed in order
	function automatic void ref_reply(input logic [7:0] op, input logic [31:0] arg);
		logic [31:0]         left;
		logic [SAMPLE_W-1:0] s0;
		logic [SAMPLE_W-1:0] s1;
		int                  k;
		left = (op == OP_READ_DATA) ? arg : 32'd4;
		k = 0;
		while (left != 0) begin
			case (op)
				OP_VERSION: exp_data.push_back(FW_VERSION);
				OP_READ_DATA: begin
					s0 = (2 * k < cap_q.size()) ? cap_q[2 * k] : '0;
					s1 = (2 * k + 1 < cap_q.size()) ? cap_q[2 * k + 1] : '0;
					exp_data.push_back({4'h0, s1, 4'h0, s0});
				end
				default: exp_data.push_back(arg);      // echo or spi byte
			endcase
			exp_keep.push_back((left >= 32'd4) ? 4'hf : 4'((32'd1 << left) - 32'd1));
			exp_last.push_back(left <= 32'd4);
			left = (left <= 32'd4) ? 32'd0 : left - 32'd4;
			k++;
		end
	endfunction

	// starts and ends on a rising edge
	task automatic send_cmd(input logic [63:0] c);
		int i;
		for (i = 0; i < CMD_BYTES; i++) begin
			i_cmd_valid <= 1'b1;
			i_cmd_data  <= c[8 * i +: 8];
			@(posedge clk);
			while (!o_cmd_ready)
				@(posedge clk);
		end
		i_cmd_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		@(posedge clk);
		while (!o_cmd_ready || exp_data.size() != 0)
			@(posedge clk);
	endtask

	task automatic adc_drive(input logic signed [SAMPLE_W-1:0] s);
		i_adc_sample <= s;
		i_adc_valid  <= 1'b1;
		@(posedge clk);
	endtask

	task automatic spi_test(input int n, input logic [2:0] cs);
		logic [31:0]       d;
		logic [BYTE_W-1:0] last_b;
		int                i;
		d        = $urandom;
		last_b   = d[8 * (n - 1) +: 8];
		exp_cs_n = ~(8'h01 << cs);
		exp_sel  = cs;
		spi_seen.delete();
		ref_reply(OP_SPI, {24'h0, ~last_b});
		send_cmd({8'(n), 8'h00, d, {5'h0, cs}, OP_SPI});
		wait_idle();
		check("spi byte count", 32'(spi_seen.size()), 32'(n));
		for (i = 0; i < n && i < spi_seen.size(); i++)
			check("o_spi_tx", 32'(spi_seen[i]), 32'(d[8 * i +: 8]));
		check("o_spi_cs_n", 32'(o_spi_cs_n), 32'hff);
	endtask

	// --------------------
	always @(posedge clk)
		i_rep_ready <= !hold_ready && ($urandom_range(0, 3) != 0);

	// spi master model
	always @(posedge clk) begin
		i_spi_rx_dv <= 1'b0;
		if (o_spi_tx_dv === 1'b1) begin
			spi_seen.push_back(o_spi_tx);
			check("o_spi_cs_n", 32'(o_spi_cs_n), 32'(exp_cs_n));
			check("o_spi_miso_sel", 32'(o_spi_miso_sel), 32'(exp_sel));
			last_tx        <= o_spi_tx;
			i_spi_tx_ready <= 1'b0;
			spi_busy       <= $urandom_range(2, 4);
		end else if (spi_busy != 0) begin
			spi_busy <= spi_busy - 1;
			if (spi_busy == 1) begin
				i_spi_rx       <= ~last_tx;
				i_spi_rx_dv    <= 1'b1;
				i_spi_tx_ready <= 1'b1;
			end
		end
	end

	// reply collector
	always @(posedge clk) begin
		if (rstn && o_rep_valid && i_rep_ready) begin
			if (exp_data.size() == 0) begin
				$display("reply word %h arrived at time %0t with no reply expected",
					o_rep_data, $time);
				err_cnt++;
			end else begin
				check("o_rep_data", o_rep_data, exp_data.pop_front());
				check("o_rep_keep", 32'(o_rep_keep), 32'(exp_keep.pop_front()));
				check("o_rep_last", 32'(o_rep_last), 32'(exp_last.pop_front()));
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("STATUS: FAIL");
		$finish;
	end

	// --------------------
	initial begin
		int                         i;
		int                         lat;
		logic signed [SAMPLE_W-1:0] v;
		void'($urandom(SEED));
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		check("o_cmd_ready", 32'(o_cmd_ready), 32'd1);
		check("o_rep_valid", 32'(o_rep_valid), 32'd0);
		check("o_spi_cs_n", 32'(o_spi_cs_n), 32'hff);
		check("o_spi_mode", 32'(o_spi_mode), 32'd0);
		end_test("reset values");

		hold_ready <= 1'b1;                              // stall the version word
		ref_reply(OP_VERSION, 32'd0);
		send_cmd({56'h0, OP_VERSION});
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!o_rep_valid);
		check("version reply latency ok", 32'(lat <= 6), 32'd1);
		repeat (5) @(posedge clk);
		hold_ready <= 1'b0;
		wait_idle();
		end_test("version read");

		ref_reply(OP_SPI_MODE, 32'd2);
		send_cmd({48'h0, 8'h02, OP_SPI_MODE});
		wait_idle();
		check("o_spi_mode", 32'(o_spi_mode), 32'd2);
		end_test("spi mode echo");

		spi_test(2, 3'd5);
		spi_test(3, 3'd0);
		spi_test(4, 3'd7);
		end_test("spi transactions");

		send_cmd({16'h0, 16'd10, 16'h0, TRIG_NONE, OP_ARM});
		wait_idle();
		repeat (10) @(posedge clk);
		cap_q.delete();
		for (i = 0; i < 12; i++) begin
			if (i == 4) begin                            // idle gap, junk sample
				i_adc_valid  <= 1'b0;
				i_adc_sample <= 12'h7ff;
				@(posedge clk);
			end
			v = 12'(i * 37 - 100);
			if (i < 10)
				cap_q.push_back(v);
			adc_drive(v);
		end
		i_adc_valid <= 1'b0;
		ref_reply(OP_READ_DATA, 32'd20);
		send_cmd({32'd20, 24'h0, OP_READ_DATA});
		wait_idle();
		end_test("immediate capture");

		send_cmd({16'h0, 16'd6, 16'h0, TRIG_THRESH, OP_ARM});
		wait_idle();
		cap_q.delete();
		adc_drive(12'sd0);
		adc_drive(-12'sd20);
		adc_drive(12'sd5);
		for (i = 0; i < 11; i++) begin
			v = 12'(30 + i);
			if (i < 6)
				cap_q.push_back(v);
			adc_drive(v);
		end
		i_adc_valid <= 1'b0;
		ref_reply(OP_READ_DATA, 32'd12);
		send_cmd({32'd12, 24'h0, OP_READ_DATA});
		wait_idle();
		end_test("threshold capture");

		ref_reply(OP_READ_DATA, 32'd6);
		send_cmd({32'd6, 24'h0, OP_READ_DATA});
		wait_idle();
		send_cmd({56'h0, 8'h07});                        // not an opcode
		wait_idle();
		repeat (20) @(posedge clk);
		ref_reply(OP_VERSION, 32'd0);
		send_cmd({56'h0, OP_VERSION});
		wait_idle();
		end_test("odd length and unknown opcode");

		$display("%0d tests, %0d failed, %0d errors", n_tests, n_fail, err_cnt);
		if (err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
common/scope_pkg.sv
command/cmd_receiver.sv
spi/spi_sequencer.sv
capture/trigger_capture.sv
logic/reply_streamer.sv
logic/scope_cmd_top.sv
bench/scope_cmd_assert.sv
bench/tb_scope_cmd.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_scope_cmd
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
